// File: filelist.f
hw/mover_pkg.sv
hw/mcu_read_if.sv
hw/mvblck_frdram.sv
hw/mcu_read_port.sv
hw/lsab_sections.sv
hw/mover_top.sv
bench/tb_mover_top.sv

// File: bench/tb_mover_top.sv
//####################################################################
// self-checking testbench for mover_top with xorshift memory data.
// moves sit away from the top of dram so addresses never wrap.
//####################################################################
module tb_mover_top;
  import mover_pkg::*;

  localparam int PERIOD       = 4;
  localparam int MOVE_CYCLES  = 64 + 2 * MCU_READ_LATENCY + 20; // longest move plus slack.
  localparam int DRAIN_CYCLES = LSAB_DEPTH + 4;
  localparam int TIMEOUT      = (DRAM_WORDS + 7 * MOVE_CYCLES + 6 * DRAIN_CYCLES + 50) * PERIOD;

  logic       CLK;
  logic       RST;
  dram_addr_t start_address;
  count_t     count_req;
  section_t   section;
  logic       issue;
  logic       load_we;
  dram_addr_t load_addr;
  word_t      load_data;
  logic       pop;
  section_t   pop_section;
  count_t     count_sent;
  logic       working;
  logic       abrupt_stop;
  word_t      pop_data;
  logic [3:0] section_empty;

  word_t       ref_mem [DRAM_WORDS];      // copy of what was loaded.
  word_t       exp_q [LSAB_SECTIONS][$];  // expected words per section.
  logic [31:0] rng;
  int          errors = 0;
  int          err_mark = 0;              // errors when the current test began.
  int          tests = 0;
  int          failed = 0;

  mover_top mover_top_inst (
    .CLK           (CLK),
    .RST           (RST),
    .start_address (start_address),
    .count_req     (count_req),
    .section       (section),
    .issue         (issue),
    .load_we       (load_we),
    .load_addr     (load_addr),
    .load_data     (load_data),
    .pop           (pop),
    .pop_section   (pop_section),
    .count_sent    (count_sent),
    .working       (working),
    .abrupt_stop   (abrupt_stop),
    .pop_data      (pop_data),
    .section_empty (section_empty)
  );

  initial
  begin
    CLK = 1'b0;
    forever #(PERIOD / 2) CLK = ~CLK;
  end

  function automatic logic [31:0] next_random(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic step_cycle();
    @(posedge CLK);
    #1; // drive and sample just after the edge.
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    assert (got === want)
    else
    begin
      $display("error %s: got %h expected %h", name, got, want);
      errors++;
    end
  endtask

  task automatic check_count(input logic [31:0] lo, input logic [31:0] hi);
    assert (count_sent >= lo && count_sent <= hi)
    else
    begin
      $display("error count_sent: got %h expected %h to %h", count_sent, lo, hi);
      errors++;
    end
  endtask

  task automatic end_test(input string name);
    tests++;
    if (errors == err_mark)
      $display("test %s: ok", name);
    else
    begin
      failed++;
      $display("test %s: failed with %0d errors", name, errors - err_mark);
    end
    err_mark = errors;
  endtask

  task automatic issue_move(input dram_addr_t addr, input count_t cnt, input section_t sec);
    start_address = addr;
    count_req     = cnt;
    section       = sec;
    issue         = 1'b1;
    step_cycle();
    issue = 1'b0;
    assert (working)
    else
    begin
      $display("working did not rise the cycle after issue");
      errors++;
    end
  endtask

  // waits for the window to close and records the words it wrote.
  task automatic finish_move(input dram_addr_t addr, input section_t sec);
    while (working)
      step_cycle();
    for (int i = 0; i < count_sent; i++)
      exp_q[sec].push_back(ref_mem[dram_addr_t'(addr + i)]); // consecutive from start.
  endtask

  task automatic drain_section(input section_t sec);
    word_t want;
    while (!section_empty[sec])
    begin
      pop         = 1'b1;
      pop_section = sec;
      step_cycle();
      pop = 1'b0;
      assert (exp_q[sec].size() != 0)
      begin
        want = exp_q[sec].pop_front();
        check_value("pop_data", pop_data, want);
      end
      else
      begin
        $display("section %0d returned a word that was never written", sec);
        errors++;
      end
    end
    assert (exp_q[sec].size() == 0)
    else
    begin
      $display("section %0d emptied with %0d words missing", sec, exp_q[sec].size());
      errors++;
    end
  endtask

  task automatic finish_run(input bit timed_out);
    $display("tests run %0d, failed %0d, errors %0d", tests, failed, errors);
    if (errors == 0 && failed == 0 && !timed_out)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  endtask

  initial
  begin
    #(TIMEOUT);
    $display("watchdog expired after %0d time units, the run hung", TIMEOUT);
    finish_run(1'b1);
  end

  initial
  begin
    RST           = 1'b0;
    start_address = '0;
    count_req     = '0;
    section       = '0;
    issue         = 1'b0;
    load_we       = 1'b0;
    load_addr     = '0;
    load_data     = '0;
    pop           = 1'b0;
    pop_section   = '0;
    rng           = 32'hdc7b9911;
    repeat (3) @(posedge CLK);
    #1;
    RST = 1'b1;

    // 1. reset state before anything moves.
    check_value("working", working, 0);
    check_value("abrupt_stop", abrupt_stop, 0);
    check_value("count_sent", count_sent, 0);
    check_value("section_empty", section_empty, 4'hf);
    end_test("reset state");

    for (int a = 0; a < DRAM_WORDS; a++)
    begin
      rng        = next_random(rng);
      ref_mem[a] = rng[15:0];
      load_we    = 1'b1;
      load_addr  = dram_addr_t'(a);
      load_data  = rng[15:0];
      step_cycle();
    end
    load_we = 1'b0;

    // 2. even start with ten words and at most one trailing extra.
    issue_move(12'h100, 6'd9, 2'd0);
    finish_move(12'h100, 2'd0);
    check_value("abrupt_stop", abrupt_stop, 0);
    check_count(10, 11);
    drain_section(2'd0);
    end_test("even-aligned block");

    // 3. odd start where the word below must not show up.
    issue_move(12'h2a5, 6'd4, 2'd2);
    finish_move(12'h2a5, 2'd2);
    check_value("abrupt_stop", abrupt_stop, 0);
    check_count(5, 6);
    drain_section(2'd2);
    end_test("odd-aligned block");

    // 4. two sections in turn while the others stay empty.
    issue_move(12'h400, 6'd7, 2'd1);
    finish_move(12'h400, 2'd1);
    check_count(8, 9);
    issue_move(12'h533, 6'd12, 2'd3);
    finish_move(12'h533, 2'd3);
    check_count(13, 14);
    check_value("section_empty", section_empty, 4'b0101);
    drain_section(2'd1);
    drain_section(2'd3);
    check_value("section_empty", section_empty, 4'hf);
    end_test("section isolation");

    // 5. second move runs into the full margin of section 0.
    issue_move(12'h800, 6'd19, 2'd0);
    finish_move(12'h800, 2'd0);
    check_value("abrupt_stop", abrupt_stop, 0);
    check_count(20, 21);
    issue_move(12'h900, 6'd29, 2'd0);
    finish_move(12'h900, 2'd0);
    check_value("abrupt_stop", abrupt_stop, 1);
    check_count(1, 29);                             // fewer than requested.
    drain_section(2'd0);
    end_test("abrupt stop");

    // 6. second issue lands mid move and must be dropped.
    issue_move(12'ha10, 6'd5, 2'd2);
    step_cycle();
    assert (working)
    else
    begin
      $display("mover went idle before the second issue");
      errors++;
    end
    start_address = 12'hc40;
    count_req     = 6'd3;
    section       = 2'd1;
    issue         = 1'b1;
    step_cycle();
    issue = 1'b0;
    finish_move(12'ha10, 2'd2);
    check_value("abrupt_stop", abrupt_stop, 0);
    check_count(6, 7);
    check_value("section_empty", section_empty, 4'b1011);
    drain_section(2'd2);
    repeat (2 * MCU_READ_LATENCY) step_cycle();    // nothing late may arrive.
    check_value("section_empty", section_empty, 4'hf);
    end_test("issue while busy");

    finish_run(1'b0);
  end

endmodule

// File: hw/mover_top.sv
//####################################################################
// one block mover feeding the lsab from a single memory read port.
// hold start_address, count_req and section valid with issue.
//####################################################################
module mover_top (
  input  logic                  CLK,
  input  logic                  RST,
  input  mover_pkg::dram_addr_t start_address,
  input  mover_pkg::count_t     count_req,
  input  mover_pkg::section_t   section,
  input  logic                  issue,
  input  logic                  load_we,
  input  mover_pkg::dram_addr_t load_addr,
  input  mover_pkg::word_t      load_data,
  input  logic                  pop,
  input  mover_pkg::section_t   pop_section,
  output mover_pkg::count_t     count_sent,
  output logic                  working,
  output logic                  abrupt_stop,
  output mover_pkg::word_t      pop_data,
  output logic [3:0]            section_empty
);
  import mover_pkg::*;

  logic       lsab_write;   // mover write window.
  section_t   lsab_section;
  logic [3:0] section_full; // back to the mover, ends a move early.

  mcu_read_if mcu_bus ();

  mvblck_frdram mvblck_inst (
    .CLK           (CLK),
    .RST           (RST),
    .start_address (start_address),
    .count_req     (count_req),
    .section       (section),
    .issue         (issue),
    .section_full  (section_full),
    .lsab_write    (lsab_write),
    .lsab_section  (lsab_section),
    .count_sent    (count_sent),
    .working       (working),
    .abrupt_stop   (abrupt_stop),
    .mcu           (mcu_bus.mover)
  );

  mcu_read_port mcu_inst (
    .CLK       (CLK),
    .RST       (RST),
    .load_we   (load_we),
    .load_addr (load_addr),
    .load_data (load_data),
    .mcu       (mcu_bus.mcu)
  );

  lsab_sections lsab_inst (
    .CLK           (CLK),
    .RST           (RST),
    .lsab_write    (lsab_write),
    .lsab_section  (lsab_section),
    .mcu           (mcu_bus.lsab),
    .section_full  (section_full),
    .pop           (pop),
    .pop_section   (pop_section),
    .pop_data      (pop_data),
    .section_empty (section_empty)
  );

endmodule

// File: hw/lsab_sections.sv
//####################################################################
// four circular word buffers over one array. a write to a section
// holding LSAB_DEPTH words is lost; a pop on an empty one is ignored.
//####################################################################
module lsab_sections (
  input  logic                CLK,
  input  logic                RST,
  input  logic                lsab_write,
  input  mover_pkg::section_t lsab_section,
  mcu_read_if.lsab            mcu,
  output logic [3:0]          section_full,
  input  logic                pop,
  input  mover_pkg::section_t pop_section,
  output mover_pkg::word_t    pop_data,
  output logic [3:0]          section_empty
);
  import mover_pkg::*;

  word_t      store [LSAB_SECTIONS*LSAB_DEPTH]; // indexed {section, ptr}.
  lsab_ptr_t  wr_ptr [LSAB_SECTIONS];
  lsab_ptr_t  rd_ptr [LSAB_SECTIONS];
  lsab_fill_t fill [LSAB_SECTIONS];
  logic       wr_ok;
  logic       pop_ok;
  logic [LSAB_SECTIONS-1:0] wr_sel;
  logic [LSAB_SECTIONS-1:0] pop_sel;

  assign wr_ok  = lsab_write && (fill[lsab_section] != lsab_fill_t'(LSAB_DEPTH));
  assign pop_ok = pop && (fill[pop_section] != '0);

  always_comb
  begin
    wr_sel  = '0;
    pop_sel = '0;
    if (wr_ok)
      wr_sel[lsab_section] = 1'b1;
    if (pop_ok)
      pop_sel[pop_section] = 1'b1;
    for (int s = 0; s < LSAB_SECTIONS; s++)
      section_empty[s] = fill[s] == '0;        // straight from the level.
  end

  // shared storage, write and pop ports.
  always_ff @(posedge CLK)
  begin
    if (wr_ok)
      store[{lsab_section, wr_ptr[lsab_section]}] <= mcu.rd_data;
    if (pop_ok)
      pop_data <= store[{pop_section, rd_ptr[pop_section]}]; // one cycle after pop.
  end

  // per section pointers, levels and full flags.
  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      for (int s = 0; s < LSAB_SECTIONS; s++)
      begin
        wr_ptr[s] <= '0;
        rd_ptr[s] <= '0;
        fill[s]   <= '0;
      end
      section_full <= '0;
    end
    else
    begin
      for (int s = 0; s < LSAB_SECTIONS; s++)
      begin
        if (wr_sel[s])
          wr_ptr[s] <= wr_ptr[s] + 1'b1;        // wraps at depth.
        if (pop_sel[s])
          rd_ptr[s] <= rd_ptr[s] + 1'b1;
        case ({wr_sel[s], pop_sel[s]})
          2'b10:   fill[s] <= fill[s] + 1'b1;
          2'b01:   fill[s] <= fill[s] - 1'b1;
          default: fill[s] <= fill[s];          // idle, or write and pop together.
        endcase
        // lags the level by a cycle, the margin absorbs it.
        section_full[s] <= fill[s] > lsab_fill_t'(LSAB_DEPTH - LSAB_FULL_MARGIN);
      end
    end
  end

endmodule

// File: hw/mcu_read_port.sv
//####################################################################
// single requester read port, no refresh and no dram writes. the load
// port fills the array and must stay idle while reads are in flight.
//####################################################################
module mcu_read_port (
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  load_we,
  input  mover_pkg::dram_addr_t load_addr,
  input  mover_pkg::word_t      load_data,
  mcu_read_if.mcu               mcu
);
  import mover_pkg::*;

  word_t      mem [DRAM_WORDS];                       // dram contents.
  dram_addr_t addr_pipe [MCU_READ_LATENCY];           // one stage per cycle.
  logic [MCU_READ_LATENCY-1:0] valid_pipe;

  // load port, testbench side.
  always_ff @(posedge CLK)
  begin
    if (load_we)
      mem[load_addr] <= load_data;
  end

  // address stages and the array read, payload only.
  always_ff @(posedge CLK)
  begin
    if (mcu.request_access)
      addr_pipe[0] <= mcu.coll_address;                  // sampled with the request.
    for (int i = 1; i < MCU_READ_LATENCY; i++)
      addr_pipe[i] <= addr_pipe[i-1];
    if (valid_pipe[MCU_READ_LATENCY-1])
      mcu.rd_data <= mem[addr_pipe[MCU_READ_LATENCY-1]]; // read in the last stage.
  end

  // valid bits follow their addresses, several reads in flight.
  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      valid_pipe   <= '0;
      mcu.rd_valid <= 1'b0;
    end
    else
    begin
      valid_pipe   <= {valid_pipe[MCU_READ_LATENCY-2:0], mcu.request_access};
      mcu.rd_valid <= valid_pipe[MCU_READ_LATENCY-1];
    end
  end

endmodule

// File: hw/mvblck_frdram.sv
//####################################################################
// moves count_req+1 words from dram into one lsab section. inputs are
// taken on issue only. the lsab must flag full with 8 words still free.
//####################################################################
module mvblck_frdram (
  input  logic                  CLK,
  input  logic                  RST,
  input  mover_pkg::dram_addr_t start_address,
  input  mover_pkg::count_t     count_req,
  input  mover_pkg::section_t   section,
  input  logic                  issue,
  input  logic [3:0]            section_full,
  output logic                  lsab_write,
  output mover_pkg::section_t   lsab_section,
  output mover_pkg::count_t     count_sent,
  output logic                  working,
  output logic                  abrupt_stop,
  mcu_read_if.mover             mcu
);

  logic       streaming;       // addresses still being issued.
  logic [6:0] len_left;        // reads left, up to 66.
  logic [6:0] read_len;
  logic       uneven_len;
  logic       trailing_pad;    // last read of the block is padding.
  logic       more_words;
  logic       target_full;
  logic       accept;
  logic [2:0] we_counter;
  logic [2:0] release_counter;
  logic       we_trigger;
  logic       release_trigger;

  // reads needed are count_req+1 plus the word below an odd start.
  assign uneven_len = count_req[0] ^ start_address[0]; // needed reads even.
  assign read_len   = ({1'b0, count_req} + 7'd2 + {6'd0, start_address[0]}) & 7'h7e;

  assign more_words  = len_left != '0;
  assign target_full = section_full[lsab_section];
  assign accept      = issue && !working; // busy issues are dropped.

  assign we_trigger      = we_counter == 3'h7;
  assign release_trigger = release_counter == 3'h7;

  // the issue cycle read hits a stale address, its word lands before the window.
  assign mcu.request_access = streaming ? (more_words && !target_full) : accept;

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      streaming        <= 1'b0;
      working          <= 1'b0;
      len_left         <= '0;
      mcu.coll_address <= '0;
      lsab_section     <= '0;
      trailing_pad     <= 1'b0;
      we_counter       <= '0;
      release_counter  <= '0;
      lsab_write       <= 1'b0;
      count_sent       <= '0;
      abrupt_stop      <= 1'b0;
    end
    else
    begin
      // both counters run once loaded and stop after wrapping to 0.
      if (release_trigger)
        we_counter <= '0;                       // window never opens after release.
      else if (we_counter != '0)
        we_counter <= we_counter + 1'b1;

      if (release_counter != '0)
        release_counter <= release_counter + 1'b1;

      if (accept)
      begin
        streaming        <= 1'b1;
        working          <= 1'b1;
        len_left         <= read_len;
        mcu.coll_address <= {start_address[11:1], 1'b0}; // even aligned stream.
        lsab_section     <= section;
        trailing_pad     <= !uneven_len;
        // word of the first address lands 6 cycles on, odd start skips one.
        if (start_address[0])
          we_counter <= 3'h1;
        else
          we_counter <= 3'h2;
      end
      else if (streaming)
      begin
        if (mcu.request_access)
        begin
          mcu.coll_address <= mcu.coll_address + 1'b1;
          len_left         <= len_left - 1'b1;
        end
        else
        begin
          streaming   <= 1'b0;
          abrupt_stop <= more_words;           // words left means target went full.
          // 3 keeps the window open until the last read lands.
          if (more_words || !trailing_pad)
            release_counter <= 3'h3;
          else
            release_counter <= 3'h4;           // drop the padding word.
        end
      end

      if (release_trigger)
      begin
        working    <= 1'b0;
        lsab_write <= 1'b0;
      end
      else if (we_trigger)
        lsab_write <= 1'b1;

      if (we_trigger || (release_trigger && !lsab_write))
        count_sent <= '0;                      // new move, nothing written yet.
      else if (lsab_write)
        count_sent <= count_sent + 1'b1;
    end
  end

endmodule

// File: hw/mcu_read_if.sv
//####################################################################
// read path of the memory controller. rd_valid is informational only,
// the buffer writes on the mover's lsab_write level.
//####################################################################
interface mcu_read_if;
  import mover_pkg::*;

  logic       request_access; // address on coll_address is read this cycle.
  dram_addr_t coll_address;
  word_t      rd_data;        // returned word, fixed latency.
  logic       rd_valid;

  modport mover (output request_access, output coll_address);
  modport mcu   (input request_access, input coll_address,
                 output rd_data, output rd_valid);
  modport lsab  (input rd_data);

endinterface

// File: hw/mover_pkg.sv
//####################################################################
// widths and timing shared by the block mover, the memory read port
// and the LSAB. the mover's window counters assume a latency of 5.
//####################################################################
package mover_pkg;

  typedef logic [15:0] word_t;      // one dram or lsab word.
  typedef logic [11:0] dram_addr_t; // dram word address.
  typedef logic [5:0]  count_t;     // block length, n moves n+1 words.
  typedef logic [1:0]  section_t;   // lsab section index.

  // whole dram address range, 2**12 words.
  localparam int unsigned DRAM_WORDS = 4096;

  // edges from the edge that samples an address to the edge
  // that puts its word on rd_data.
  localparam int unsigned MCU_READ_LATENCY = 5;

  localparam int unsigned LSAB_SECTIONS    = 4;  // one per section_t code.
  localparam int unsigned LSAB_DEPTH       = 32; // words per section.
  localparam int unsigned LSAB_FULL_MARGIN = 8;  // full while fewer free than this.

  typedef logic [$clog2(LSAB_DEPTH)-1:0] lsab_ptr_t;  // wraps at the depth.
  typedef logic [$clog2(LSAB_DEPTH):0]   lsab_fill_t; // 0 up to depth inclusive.

endpackage
